// File: sgd_consts.svh
////////////////////////////////////////
// sgd constants
// sample geometry and field widths
////////////////////////////////////////
`ifndef SGD_CONSTS_SVH
`define SGD_CONSTS_SVH

// features per sample
`define SGD_NUM_FEATURES 8

// bits per feature, one plane per bit
`define SGD_FEATURE_BITS 4

// model, label, loss and gradient words
`define SGD_WORD_W 32

// run configuration field widths
`define SGD_BATCH_W 8
`define SGD_SAMPLES_W 16
`define SGD_SHIFT_W 5

`endif

// File: sgd_pkg.sv
////////////////////////////////////////
// sgd types
// structs passed between the sgd stages
////////////////////////////////////////
`default_nettype none
`include "sgd_consts.svh"

package sgd_pkg;

    // one signed model or gradient word
    typedef logic signed [`SGD_WORD_W-1:0] sgd_word_t;

    // run configuration, taken with start
    typedef struct packed {
        logic [`SGD_BATCH_W-1:0]   mini_batch_size;
        logic [`SGD_SHIFT_W-1:0]   step_shift;
        logic [`SGD_SAMPLES_W-1:0] number_of_samples;
    } sgd_cfg_t;

    // host plane, label only meaningful on the first plane
    typedef struct packed {
        logic [`SGD_NUM_FEATURES-1:0] bits;
        sgd_word_t                    label;
    } sgd_plane_in_t;

    // plane tagged with its place in sample, batch and run
    typedef struct packed {
        logic [`SGD_NUM_FEATURES-1:0] bits;
        sgd_word_t                    label;
        logic                         first;
        logic                         sample_last;
        logic                         batch_end;
        logic                         run_end;
    } sgd_plane_t;

    // rebuilt sample; label slot holds dot minus label
    typedef struct packed {
        logic [`SGD_NUM_FEATURES-1:0][`SGD_FEATURE_BITS-1:0] features;
        sgd_word_t                                          label;
        logic                                               batch_end;
        logic                                               run_end;
    } sgd_sample_t;

    // indexed model word for writeback
    typedef struct packed {
        logic [$clog2(`SGD_NUM_FEATURES)-1:0] index;
        sgd_word_t                            value;
    } sgd_model_word_t;

    // full model, word f at index f
    typedef sgd_word_t [`SGD_NUM_FEATURES-1:0] sgd_model_t;

endpackage

`default_nettype wire

// File: sgd_plane_decode.sv
////////////////////////////////////////
// sgd plane decode
// counts planes and samples, tags each plane
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "sgd_consts.svh"

module sgd_plane_decode (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   start,
    input  sgd_pkg::sgd_cfg_t      cfg,
    input  logic                   plane_valid,
    input  sgd_pkg::sgd_plane_in_t plane_in,
    output logic                   dec_valid,
    output sgd_pkg::sgd_plane_t    dec_plane
);
    import sgd_pkg::*;

    localparam int PLANE_W = $clog2(`SGD_FEATURE_BITS);

    // latched run configuration
    logic [`SGD_BATCH_W-1:0]   batch_size_r;
    logic [`SGD_SAMPLES_W-1:0] num_samples_r;

    // position counters
    logic [PLANE_W-1:0]        plane_cnt;
    logic [`SGD_BATCH_W-1:0]   batch_cnt;
    logic [`SGD_SAMPLES_W-1:0] sample_cnt;

    logic is_first;
    logic is_last;
    logic last_of_run;
    logic last_of_batch;

    assign is_first = (plane_cnt == '0);
    assign is_last  = (plane_cnt == PLANE_W'(`SGD_FEATURE_BITS - 1));
    // tags only hold on the last plane of a sample
    assign last_of_run   = is_last && (sample_cnt + `SGD_SAMPLES_W'(1) == num_samples_r);
    assign last_of_batch = is_last &&
                           ((batch_cnt + `SGD_BATCH_W'(1) == batch_size_r) || last_of_run);

    ////////////////////////////////////////
    // control
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            batch_size_r  <= '0;
            num_samples_r <= '0;
            plane_cnt     <= '0;
            batch_cnt     <= '0;
            sample_cnt    <= '0;
            dec_valid     <= 1'b0;
        end
        else if (start)
        begin
            batch_size_r  <= cfg.mini_batch_size;
            num_samples_r <= cfg.number_of_samples;
            plane_cnt     <= '0;
            batch_cnt     <= '0;
            sample_cnt    <= '0;
            dec_valid     <= 1'b0;
        end
        else
        begin
            dec_valid <= plane_valid;
            if (plane_valid)
            begin
                plane_cnt <= is_last ? '0 : plane_cnt + PLANE_W'(1);
                if (is_last)
                begin
                    sample_cnt <= sample_cnt + `SGD_SAMPLES_W'(1);
                    // batch counter wraps at each mini-batch end
                    batch_cnt  <= last_of_batch ? '0 : batch_cnt + `SGD_BATCH_W'(1);
                end
            end
        end
    end

    ////////////////////////////////////////
    // tagged plane payload
    always_ff @(posedge clk)
    begin
        if (plane_valid)
        begin
            dec_plane.bits        <= plane_in.bits;
            dec_plane.label       <= plane_in.label;
            dec_plane.first       <= is_first;
            dec_plane.sample_last <= is_last;
            dec_plane.batch_end   <= last_of_batch;
            dec_plane.run_end     <= last_of_run;
        end
    end

endmodule

`default_nettype wire

// File: sgd_dot_product.sv
////////////////////////////////////////
// sgd dot product
// bit-serial dot product, rebuilds features
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "sgd_consts.svh"

module sgd_dot_product (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 dec_valid,
    input  sgd_pkg::sgd_plane_t  dec_plane,
    input  sgd_pkg::sgd_model_t  model,
    output logic                 smp_valid,
    output sgd_pkg::sgd_sample_t sample
);
    import sgd_pkg::*;

    localparam int NF = `SGD_NUM_FEATURES;
    localparam int FB = `SGD_FEATURE_BITS;

    // running partial dot product
    sgd_word_t acc_r;
    sgd_word_t acc_next;
    // label of the sample in progress
    sgd_word_t label_r;

    // features rebuilt msb first
    logic [NF-1:0][FB-1:0] feat_r;
    logic [NF-1:0][FB-1:0] feat_next;

    ////////////////////////////////////////
    // one plane step
    always_comb
    begin
        // msb plane first, so double what is there
        acc_next = dec_plane.first ? '0 : (acc_r << 1);
        for (int f = 0; f < NF; f++)
        begin
            // plane bit set, add that model word
            if (dec_plane.bits[f])
            begin
                acc_next = acc_next + model[f];
            end
            feat_next[f] = {feat_r[f][FB-2:0], dec_plane.bits[f]};
        end
    end

    // old bits fall out after FB planes, no clear needed
    always_ff @(posedge clk)
    begin
        if (dec_valid)
        begin
            acc_r  <= acc_next;
            feat_r <= feat_next;
            if (dec_plane.first)
            begin
                label_r <= dec_plane.label;
            end
        end
    end

    ////////////////////////////////////////
    // sample output
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            smp_valid <= 1'b0;
        end
        else
        begin
            smp_valid <= dec_valid && dec_plane.sample_last;
        end
    end

    always_ff @(posedge clk)
    begin
        if (dec_valid && dec_plane.sample_last)
        begin
            sample.features  <= feat_next;
            // unshifted loss, wraps mod 2^32
            sample.label     <= acc_next - label_r;
            sample.batch_end <= dec_plane.batch_end;
            sample.run_end   <= dec_plane.run_end;
        end
    end

endmodule

`default_nettype wire

// File: sgd_gradient.sv
////////////////////////////////////////
// sgd gradient
// loss, gradient sums and mini-batch update
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "sgd_consts.svh"

module sgd_gradient (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    start,
    input  logic [`SGD_SHIFT_W-1:0] step_shift,
    input  logic                    smp_valid,
    input  sgd_pkg::sgd_sample_t    sample,
    output sgd_pkg::sgd_model_t     model,
    output logic                    run_complete
);
    import sgd_pkg::*;

    localparam int NF = `SGD_NUM_FEATURES;
    localparam int FB = `SGD_FEATURE_BITS;
    localparam int W  = `SGD_WORD_W;

    logic [`SGD_SHIFT_W-1:0] shift_r;

    // stage 1, shifted loss with its sample
    sgd_word_t             loss_r;
    logic                  loss_valid;
    logic [NF-1:0][FB-1:0] feat_r;
    logic                  batch_end_r;
    logic                  run_end_r;

    // stage 2, gradient sums
    sgd_model_t grad;
    logic       upd_pending;
    logic       run_pending;

    // loss times feature, per feature
    sgd_model_t prod;

    always_comb
    begin
        for (int f = 0; f < NF; f++)
        begin
            // features are unsigned, zero extend before the signed multiply
            prod[f] = loss_r * $signed({{(W - FB){1'b0}}, feat_r[f]});
        end
    end

    ////////////////////////////////////////
    // stage 1 payload
    always_ff @(posedge clk)
    begin
        if (smp_valid)
        begin
            loss_r      <= $signed(sample.label) >>> shift_r;
            feat_r      <= sample.features;
            batch_end_r <= sample.batch_end;
            run_end_r   <= sample.run_end;
        end
    end

    ////////////////////////////////////////
    // control, gradients and model
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            shift_r      <= '0;
            loss_valid   <= 1'b0;
            upd_pending  <= 1'b0;
            run_pending  <= 1'b0;
            run_complete <= 1'b0;
            grad         <= '0;
            model        <= '0;
        end
        else if (start)
        begin
            // every run starts from a zero model
            shift_r      <= step_shift;
            loss_valid   <= 1'b0;
            upd_pending  <= 1'b0;
            run_pending  <= 1'b0;
            run_complete <= 1'b0;
            grad         <= '0;
            model        <= '0;
        end
        else
        begin
            loss_valid   <= smp_valid;
            upd_pending  <= loss_valid && batch_end_r;
            run_pending  <= loss_valid && run_end_r;
            run_complete <= run_pending;
            for (int f = 0; f < NF; f++)
            begin
                if (upd_pending)
                begin
                    // apply the batch, sums start over
                    model[f] <= model[f] - grad[f];
                    grad[f]  <= '0;
                end
                else if (loss_valid)
                begin
                    grad[f] <= grad[f] + prod[f];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: sgd_model_writeback.sv
////////////////////////////////////////
// sgd model writeback
// streams the final model, then done
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "sgd_consts.svh"

module sgd_model_writeback (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     run_complete,
    input  sgd_pkg::sgd_model_t      model,
    output logic                     model_valid,
    output sgd_pkg::sgd_model_word_t model_word,
    output logic                     done
);
    import sgd_pkg::*;

    localparam int IDX_W = $clog2(`SGD_NUM_FEATURES);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`SGD_NUM_FEATURES - 1);

    // frozen model and next word to send
    sgd_model_t       snap_r;
    logic             busy;
    logic [IDX_W-1:0] idx_r;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            model_valid <= 1'b0;
            done        <= 1'b0;
            busy        <= 1'b0;
            idx_r       <= '0;
        end
        else
        begin
            model_valid <= 1'b0;
            // one cycle after the last word
            done        <= model_valid && (model_word.index == LAST_IDX);
            if (run_complete)
            begin
                // word 0 goes out right away
                model_valid <= 1'b1;
                busy        <= 1'b1;
                idx_r       <= IDX_W'(1);
            end
            else if (busy)
            begin
                model_valid <= 1'b1;
                idx_r       <= idx_r + IDX_W'(1);
                if (idx_r == LAST_IDX)
                begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // word payload
    always_ff @(posedge clk)
    begin
        if (run_complete)
        begin
            snap_r           <= model;
            model_word.index <= '0;
            model_word.value <= model[0];
        end
        else if (busy)
        begin
            model_word.index <= idx_r;
            model_word.value <= snap_r[idx_r];
        end
    end

endmodule

`default_nettype wire

// File: sgd_top.sv
////////////////////////////////////////
// sgd top
// decode, execute and writeback chain
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sgd_top (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     start,
    input  sgd_pkg::sgd_cfg_t        cfg,
    input  logic                     plane_valid,
    input  sgd_pkg::sgd_plane_in_t   plane_in,
    output logic                     model_valid,
    output sgd_pkg::sgd_model_word_t model_word,
    output logic                     done
);
    import sgd_pkg::*;

    // decode to dot product
    logic        dec_valid;
    sgd_plane_t  dec_plane;

    // dot product to gradient
    logic        smp_valid;
    sgd_sample_t sample;

    // gradient to dot product and writeback
    sgd_model_t  model;
    logic        run_complete;

    ////////////////////////////////////////
    // decode
    sgd_plane_decode u_decode (
        .clk         (clk),
        .arst_n      (arst_n),
        .start       (start),
        .cfg         (cfg),
        .plane_valid (plane_valid),
        .plane_in    (plane_in),
        .dec_valid   (dec_valid),
        .dec_plane   (dec_plane)
    );

    ////////////////////////////////////////
    // execute
    sgd_dot_product u_dot (
        .clk       (clk),
        .arst_n    (arst_n),
        .dec_valid (dec_valid),
        .dec_plane (dec_plane),
        .model     (model),
        .smp_valid (smp_valid),
        .sample    (sample)
    );

    // only the step shift is needed past decode
    sgd_gradient u_grad (
        .clk          (clk),
        .arst_n       (arst_n),
        .start        (start),
        .step_shift   (cfg.step_shift),
        .smp_valid    (smp_valid),
        .sample       (sample),
        .model        (model),
        .run_complete (run_complete)
    );

    ////////////////////////////////////////
    // result
    sgd_model_writeback u_wb (
        .clk          (clk),
        .arst_n       (arst_n),
        .run_complete (run_complete),
        .model        (model),
        .model_valid  (model_valid),
        .model_word   (model_word),
        .done         (done)
    );

endmodule

`default_nettype wire

// File: sgd_properties.sv
////////////////////////////////////////
// sgd properties
// host rules and strobe protocol checks
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "sgd_consts.svh"

module sgd_properties (
    input logic                     clk,
    input logic                     arst_n,
    input logic                     plane_valid,
    input logic                     dec_valid,
    input sgd_pkg::sgd_plane_t      dec_plane,
    input logic                     model_valid,
    input sgd_pkg::sgd_model_word_t model_word,
    input logic                     done
);
    import sgd_pkg::*;

    localparam int IDX_W = $clog2(`SGD_NUM_FEATURES);
    localparam int CNT_W = IDX_W + 1;

    logic             batch_end_seen;
    logic             last_word;
    // place of the current word in the stream
    logic [CNT_W-1:0] word_cnt;

    assign batch_end_seen = dec_valid && dec_plane.batch_end;
    assign last_word      = model_valid && (word_cnt == CNT_W'(`SGD_NUM_FEATURES - 1));

    // consecutive model word strobes
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            word_cnt <= '0;
        end
        else
        begin
            word_cnt <= model_valid ? word_cnt + CNT_W'(1) : '0;
        end
    end

    // four quiet cycles after a mini-batch end
    a_batch_gap: assert property (@(posedge clk) disable iff (!arst_n)
        plane_valid |-> !batch_end_seen && !$past(batch_end_seen, 1)
                        && !$past(batch_end_seen, 2) && !$past(batch_end_seen, 3))
        else $error("plane strobe inside the mini-batch gap");

    // four planes per sample, first to last
    a_plane_count: assert property (@(posedge clk) disable iff (!arst_n)
        (dec_valid && dec_plane.sample_last) |-> $past(dec_valid, 1) && $past(dec_valid, 2)
                                                 && $past(dec_valid && dec_plane.first, 3))
        else $error("sample did not carry four planes");

    // words in index order, eight at most
    a_word_order: assert property (@(posedge clk) disable iff (!arst_n)
        model_valid |-> (word_cnt < CNT_W'(`SGD_NUM_FEATURES))
                        && (model_word.index == word_cnt[IDX_W-1:0]))
        else $error("model word out of index order");

    a_valid_done: assert property (@(posedge clk) disable iff (!arst_n)
        !(model_valid && done))
        else $error("model_valid and done high together");

    a_done_after_last: assert property (@(posedge clk) disable iff (!arst_n)
        last_word |=> done)
        else $error("done missing after the last model word");

    a_done_source: assert property (@(posedge clk) disable iff (!arst_n)
        done |-> $past(last_word))
        else $error("done without a preceding last model word");

endmodule

bind sgd_top sgd_properties u_props (
    .clk         (clk),
    .arst_n      (arst_n),
    .plane_valid (plane_valid),
    .dec_valid   (dec_valid),
    .dec_plane   (dec_plane),
    .model_valid (model_valid),
    .model_word  (model_word),
    .done        (done)
);

`default_nettype wire

// File: tb_sgd.sv
////////////////////////////////////////
// sgd testbench
// directed runs against a reference model
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "sgd_consts.svh"

module tb_sgd;
    import sgd_pkg::*;

    localparam int NF = `SGD_NUM_FEATURES;
    localparam int FB = `SGD_FEATURE_BITS;
    localparam int W  = `SGD_WORD_W;
    // runs take about 200 cycles in all, doubled for margin
    localparam int TIMEOUT_CYCLES = 400;
    // last plane strobe to first model word
    localparam int WB_LATENCY = 6;

    logic            clk;
    logic            arst_n;
    logic            start;
    sgd_cfg_t        cfg;
    logic            plane_valid;
    sgd_plane_in_t   plane_in;
    logic            model_valid;
    sgd_model_word_t model_word;
    logic            done;

    // samples of the current run and the expected model
    logic [FB-1:0]         feat [8][NF];
    logic signed [W-1:0]   lab [8];
    logic [W-1:0]          exp_model [NF];

    logic [15:0] lfsr;
    int          cycles;
    int          checks;
    int          errors;

    sgd_top dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .start       (start),
        .cfg         (cfg),
        .plane_valid (plane_valid),
        .plane_in    (plane_in),
        .model_valid (model_valid),
        .model_word  (model_word),
        .done        (done)
    );

    always #2 clk = ~clk;

    ////////////////////////////////////////
    // stimulus source
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        // galois form, x^16 + x^14 + x^13 + x^11
        lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one lfsr step per bit
    task automatic take_bits(input int n, output logic [W-1:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v    = {v[W-2:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic gen_samples(input int n);
        logic [W-1:0] v;
        for (int s = 0; s < n; s++)
        begin
            for (int f = 0; f < NF; f++)
            begin
                take_bits(FB, v);
                feat[s][f] = v[FB-1:0];
            end
            // small signed label, 12 bits
            take_bits(12, v);
            lab[s] = {{20{v[11]}}, v[11:0]};
        end
    endtask

    ////////////////////////////////////////
    // reference model
    task automatic ref_run(input int n, input int bsize, input int shift);
        logic signed [W-1:0] m [NF];
        logic signed [W-1:0] g [NF];
        logic signed [W-1:0] dot;
        logic signed [W-1:0] loss;
        int                  in_batch;
        in_batch = 0;
        for (int f = 0; f < NF; f++)
        begin
            m[f] = '0;
            g[f] = '0;
        end
        for (int s = 0; s < n; s++)
        begin
            // whole batch sees the model from its start
            dot = '0;
            for (int f = 0; f < NF; f++)
            begin
                dot = dot + m[f] * int'(feat[s][f]);
            end
            loss = (dot - lab[s]) >>> shift;
            for (int f = 0; f < NF; f++)
            begin
                g[f] = g[f] + loss * int'(feat[s][f]);
            end
            in_batch++;
            if (in_batch == bsize || s == n - 1)
            begin
                for (int f = 0; f < NF; f++)
                begin
                    m[f] = m[f] - g[f];
                    g[f] = '0;
                end
                in_batch = 0;
            end
        end
        for (int f = 0; f < NF; f++)
        begin
            exp_model[f] = m[f];
        end
    endtask

    ////////////////////////////////////////
    // helpers
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [W-1:0] got,
                               input logic [W-1:0] exp);
        checks++;
        assert (got == exp)
        else
        begin
            errors++;
            $display("ERR %0t %s expected %0h got %0h", $time, name, exp, got);
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        checks++;
        assert (cond)
        else
        begin
            errors++;
            $display("at %0t: %s", $time, what);
        end
    endtask

    // one full run, then the writeback stream
    task automatic run_sgd(input int n, input int bsize, input int shift);
        int lat;
        next_cycle();
        start                 = 1'b1;
        cfg.mini_batch_size   = `SGD_BATCH_W'(bsize);
        cfg.step_shift        = `SGD_SHIFT_W'(shift);
        cfg.number_of_samples = `SGD_SAMPLES_W'(n);
        for (int s = 0; s < n; s++)
        begin
            // msb plane first
            for (int p = FB - 1; p >= 0; p--)
            begin
                next_cycle();
                start       = 1'b0;
                plane_valid = 1'b1;
                for (int f = 0; f < NF; f++)
                begin
                    plane_in.bits[f] = feat[s][f][p];
                end
                plane_in.label = (p == FB - 1) ? lab[s] : '0;
            end
            // gap after a mini-batch so the update lands first
            if ((s + 1) % bsize == 0 && s != n - 1)
            begin
                repeat (4)
                begin
                    next_cycle();
                    plane_valid = 1'b0;
                end
            end
        end
        next_cycle();
        plane_valid = 1'b0;
        lat = 1;
        while (!model_valid && lat < 20)
        begin
            next_cycle();
            lat++;
        end
        expect_true(model_valid, "no model word came after the last plane");
        check_value("model_valid latency", W'(lat), W'(WB_LATENCY));
        for (int i = 0; i < NF; i++)
        begin
            expect_true(model_valid, "model_valid dropped inside the word stream");
            check_value("model_word.index", W'(model_word.index), W'(i));
            check_value("model_word.value", model_word.value, exp_model[i]);
            next_cycle();
        end
        expect_true(done, "done did not follow the eighth word");
        expect_true(!model_valid, "model_valid high together with done");
        next_cycle();
        expect_true(!done, "done stayed high for more than one cycle");
    endtask

    ////////////////////////////////////////
    // tests
    task automatic test_reset_idle();
        repeat (10)
        begin
            next_cycle();
            expect_true(!model_valid && !done, "output strobe with no stimulus");
        end
    endtask

    task automatic test_single_sample();
        gen_samples(1);
        ref_run(1, 1, 2);
        run_sgd(1, 1, 2);
    endtask

    task automatic test_two_batches();
        gen_samples(6);
        ref_run(6, 3, 3);
        run_sgd(6, 3, 3);
    endtask

    task automatic test_partial_batch();
        gen_samples(5);
        ref_run(5, 2, 1);
        run_sgd(5, 2, 1);
    endtask

    // same samples twice, start must wipe the model
    task automatic test_restart();
        gen_samples(4);
        ref_run(4, 4, 2);
        run_sgd(4, 4, 2);
        run_sgd(4, 4, 2);
    endtask

    ////////////////////////////////////////
    // main sequence
    initial
    begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        start       = 1'b0;
        cfg         = '0;
        plane_valid = 1'b0;
        plane_in    = '0;
        lfsr        = 16'd57;
        cycles      = 0;
        checks      = 0;
        errors      = 0;
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;
        test_reset_idle();
        test_single_sample();
        test_two_batches();
        test_partial_batch();
        test_restart();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0)
        begin
            $display("test passed");
        end
        else
        begin
            $display("test failed");
        end
        $finish;
    end

    // run limit
    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("timeout, run did not finish in %0d cycles", TIMEOUT_CYCLES);
            $display("checks %0d errors %0d", checks, errors);
            $display("test failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+.
sgd_pkg.sv
sgd_plane_decode.sv
sgd_dot_product.sv
sgd_gradient.sv
sgd_model_writeback.sv
sgd_top.sv
sgd_properties.sv
tb_sgd.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the sgd testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_sgd \
    -o sim_sgd > build.log 2>&1 \
    || { cat build.log; echo "build error"; exit 1; }

./obj_dir/sim_sgd > sim.log 2>&1
cat sim.log

grep -qx "test passed" sim.log && echo "simulation ok" && exit 0 \
    || { echo "simulation reported failure"; exit 1; }
